// ==== flist.f ====
+incdir+tests
rtl/riscv_mext_pkg.sv
rtl/riscv_multiplier.sv
rtl/riscv_divider.sv
rtl/riscv_mext_result_sel.sv
rtl/riscv_mext_wb_regs.sv
rtl/riscv_mext_top.sv
tests/tb_riscv_mext.sv

// ==== rtl/riscv_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_divider #(
    parameter int XLEN = 64
) (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_start,
    input  wire [XLEN-1:0]                i_rs1,
    input  wire [XLEN-1:0]                i_rs2,
    input  wire riscv_mext_pkg::mext_op_e i_op,
    output logic [XLEN-1:0]               o_result,
    output logic                          o_done
);

    localparam int CW = $clog2(XLEN);

    logic                     running;      // iteration loop active
    logic                     done_q;
    logic [CW-1:0]            count;        // steps already taken
    logic [XLEN-1:0]          rem_q;
    logic [XLEN-1:0]          quo_q;        // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]          div_q;        // divisor magnitude
    logic                     neg_quo;
    logic                     neg_rem;
    logic                     div_zero;
    riscv_mext_pkg::mext_op_e op_q;

    logic            op_signed;
    logic [XLEN-1:0] rs1_mag;
    logic [XLEN-1:0] rs2_mag;
    logic [XLEN-1:0] src_rem;
    logic [XLEN-1:0] src_quo;
    logic [XLEN-1:0] src_div;
    logic [XLEN:0]   partial;
    logic [XLEN:0]   diff;
    logic [XLEN-1:0] step_rem;
    logic [XLEN-1:0] step_quo;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    assign op_signed = ~i_op[0];            // DIV and REM
    assign rs1_mag   = (op_signed && i_rs1[XLEN-1]) ? (~i_rs1 + 1'b1) : i_rs1;
    assign rs2_mag   = (op_signed && i_rs2[XLEN-1]) ? (~i_rs2 + 1'b1) : i_rs2;

    // ------------------------------
    // one restoring step
    // ------------------------------
    // the first step runs on the start edge straight from the operands,
    // so XLEN steps finish XLEN edges after start
    always_comb
    begin
        src_rem  = i_start ? '0 : rem_q;
        src_quo  = i_start ? rs1_mag : quo_q;
        src_div  = i_start ? rs2_mag : div_q;
        partial  = {src_rem, src_quo[XLEN-1]};
        diff     = partial - {1'b0, src_div};
        step_quo = {src_quo[XLEN-2:0], ~diff[XLEN]};
        step_rem = diff[XLEN] ? partial[XLEN-1:0] : diff[XLEN-1:0];   // restore on borrow
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            running <= 1'b0;
            done_q  <= 1'b0;
            count   <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (i_start)
            begin
                running <= 1'b1;
                count   <= CW'(1);
            end
            else if (running)
            begin
                count <= count + 1'b1;
                if (count == CW'(XLEN - 1))                         // last step
                begin
                    running <= 1'b0;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            op_q     <= i_op;
            div_q    <= rs2_mag;
            div_zero <= (i_rs2 == '0);
            neg_quo  <= op_signed & (i_rs1[XLEN-1] ^ i_rs2[XLEN-1]) & (i_rs2 != '0);
            neg_rem  <= op_signed & i_rs1[XLEN-1];
        end
        if (i_start || running)
        begin
            rem_q <= step_rem;
            quo_q <= step_quo;
        end
    end

    // ------------------------------
    // sign fix and select
    // ------------------------------
    // signed overflow needs no override: |min| / 1 leaves min with no negation
    assign quo_fix  = div_zero ? '1 : (neg_quo ? (~quo_q + 1'b1) : quo_q);
    assign rem_fix  = neg_rem ? (~rem_q + 1'b1) : rem_q;    // remainder takes dividend sign
    assign o_result = op_q[1] ? rem_fix : quo_fix;          // REM and REMU
    assign o_done   = done_q;

    // the bus slave holds off new operations until the result is taken
    a_no_start_while_running: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !running && !done_q
    );

endmodule

`default_nettype wire

// ==== rtl/riscv_mext_pkg.sv ====
`default_nettype none

package riscv_mext_pkg;

    // ------------------------------
    // M extension funct3 codes
    // ------------------------------
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,                    // bit 2 set selects the divider
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } mext_op_e;

    // ------------------------------
    // wishbone word addresses
    // ------------------------------
    localparam logic [2:0] REG_RS1    = 3'd0;
    localparam logic [2:0] REG_RS2    = 3'd1;
    localparam logic [2:0] REG_OP     = 3'd2;   // write starts an operation
    localparam logic [2:0] REG_RESULT = 3'd3;
    localparam logic [2:0] REG_STATUS = 3'd4;   // busy in bit 0

    localparam int XLEN_DEFAULT = 64;

endpackage

`default_nettype wire

// ==== rtl/riscv_mext_result_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mext_result_sel #(
    parameter int XLEN = 64
) (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_start,
    input  wire riscv_mext_pkg::mext_op_e i_op,
    input  wire [XLEN-1:0]                i_mul_product,
    input  wire [XLEN-1:0]                i_div_result,
    input  wire                           i_div_done,
    output logic [XLEN-1:0]               o_result,
    output logic                          o_busy
);

    logic            busy_q;                // divide in progress
    logic [XLEN-1:0] result_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            busy_q   <= 1'b0;
            result_q <= '0;
        end
        else if (i_start)
        begin
            if (i_op[2])
                busy_q <= 1'b1;             // wait for the divider
            else
                result_q <= i_mul_product;  // product ready in the start cycle
        end
        else if (i_div_done)
        begin
            result_q <= i_div_result;
            busy_q   <= 1'b0;
        end
    end

    // the start cycle itself counts as busy
    assign o_busy   = busy_q | i_start;
    assign o_result = result_q;

    // op stays stable on the bus side for the whole divide
    a_done_only_in_divide: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_div_done |-> busy_q && i_op[2]
    );

endmodule

`default_nettype wire

// ==== rtl/riscv_mext_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mext_top #(
    parameter int XLEN = riscv_mext_pkg::XLEN_DEFAULT
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_wb_cyc,
    input  wire              i_wb_stb,
    input  wire              i_wb_we,
    input  wire [2:0]        i_wb_adr,
    input  wire [XLEN-1:0]   i_wb_dat,
    output logic [XLEN-1:0]  o_wb_dat,
    output logic             o_wb_ack
);

    logic [XLEN-1:0]          rs1;
    logic [XLEN-1:0]          rs2;
    riscv_mext_pkg::mext_op_e op;
    logic                     start;
    logic                     div_start;
    logic [XLEN-1:0]          mul_product;
    logic [XLEN-1:0]          div_result;
    logic                     div_done;
    logic [XLEN-1:0]          result;
    logic                     busy;

    riscv_mext_wb_regs #(.XLEN(XLEN)) u_wb_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack),
        .i_busy      (busy),
        .i_result    (result),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_op        (op),
        .o_start     (start),
        .o_div_start (div_start)
    );

    riscv_multiplier #(.XLEN(XLEN)) u_multiplier (
        .i_riscv_mul_rs1data (rs1),
        .i_riscv_mul_rs2data (rs2),
        .i_riscv_mul_op      (op),
        .o_riscv_mul_product (mul_product)
    );

    riscv_divider #(.XLEN(XLEN)) u_divider (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (div_start),              // divide codes only
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_op     (op),
        .o_result (div_result),
        .o_done   (div_done)
    );

    riscv_mext_result_sel #(.XLEN(XLEN)) u_result_sel (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (start),
        .i_op          (op),
        .i_mul_product (mul_product),
        .i_div_result  (div_result),
        .i_div_done    (div_done),
        .o_result      (result),
        .o_busy        (busy)
    );

endmodule

`default_nettype wire

// ==== rtl/riscv_mext_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_mext_wb_regs #(
    parameter int XLEN = 64
) (
    input  wire                            i_clk,
    input  wire                            i_rst_n,
    input  wire                            i_wb_cyc,
    input  wire                            i_wb_stb,
    input  wire                            i_wb_we,
    input  wire [2:0]                      i_wb_adr,
    input  wire [XLEN-1:0]                 i_wb_dat,
    output logic [XLEN-1:0]                o_wb_dat,
    output logic                           o_wb_ack,
    input  wire                            i_busy,
    input  wire [XLEN-1:0]                 i_result,
    output logic [XLEN-1:0]                o_rs1,
    output logic [XLEN-1:0]                o_rs2,
    output riscv_mext_pkg::mext_op_e       o_op,
    output logic                           o_start,
    output logic                           o_div_start
);

    logic                     ack_q;
    logic                     start_q;
    logic [XLEN-1:0]          rs1_q;
    logic [XLEN-1:0]          rs2_q;
    riscv_mext_pkg::mext_op_e op_q;
    logic [XLEN-1:0]          rd_dat_q;

    logic                     req;
    logic                     stall;
    logic                     accept;
    logic [XLEN-1:0]          rd_mux;

    assign req    = i_wb_cyc & i_wb_stb & ~ack_q;   // one ack per request
    assign stall  = i_busy & ((i_wb_we & (i_wb_adr == riscv_mext_pkg::REG_OP)) |
                              (~i_wb_we & (i_wb_adr == riscv_mext_pkg::REG_RESULT)));
    assign accept = req & ~stall;

    // ------------------------------
    // register writes
    // ------------------------------
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
            rs1_q   <= '0;
            rs2_q   <= '0;
            op_q    <= riscv_mext_pkg::MUL;
        end
        else
        begin
            ack_q   <= accept;
            start_q <= 1'b0;
            if (accept && i_wb_we)
            begin
                case (i_wb_adr)
                    riscv_mext_pkg::REG_RS1: rs1_q <= i_wb_dat;
                    riscv_mext_pkg::REG_RS2: rs2_q <= i_wb_dat;
                    riscv_mext_pkg::REG_OP:
                    begin
                        op_q    <= riscv_mext_pkg::mext_op_e'(i_wb_dat[2:0]);
                        start_q <= 1'b1;    // one cycle pulse
                    end
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------
    // read path
    // ------------------------------
    always_comb
    begin
        case (i_wb_adr)
            riscv_mext_pkg::REG_RS1:    rd_mux = rs1_q;
            riscv_mext_pkg::REG_RS2:    rd_mux = rs2_q;
            riscv_mext_pkg::REG_OP:     rd_mux = {{(XLEN-3){1'b0}}, op_q};
            riscv_mext_pkg::REG_RESULT: rd_mux = i_result;
            riscv_mext_pkg::REG_STATUS: rd_mux = {{(XLEN-1){1'b0}}, i_busy};
            default:                    rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
            rd_dat_q <= rd_mux;             // sampled with the ack
    end

    assign o_wb_dat    = rd_dat_q;
    assign o_wb_ack    = ack_q;
    assign o_rs1       = rs1_q;
    assign o_rs2       = rs2_q;
    assign o_op        = op_q;
    assign o_start     = start_q;
    assign o_div_start = start_q & op_q[2];

    // the master keeps the strobe up until it sees the ack
    a_ack_in_cycle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_wb_ack |-> i_wb_cyc && i_wb_stb
    );

endmodule

`default_nettype wire

// ==== rtl/riscv_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_multiplier #(
    parameter int XLEN = 64
) (
    input  wire [XLEN-1:0]                i_riscv_mul_rs1data,
    input  wire [XLEN-1:0]                i_riscv_mul_rs2data,
    input  wire riscv_mext_pkg::mext_op_e i_riscv_mul_op,
    output logic [XLEN-1:0]               o_riscv_mul_product
);

    logic              rs1_signed;          // operand treated as two's complement
    logic              rs2_signed;
    logic              rs1_neg;
    logic              rs2_neg;
    logic [XLEN-1:0]   rs1_mag;
    logic [XLEN-1:0]   rs2_mag;
    logic [2*XLEN-1:0] sum;                 // unsigned product of magnitudes
    logic [2*XLEN-1:0] prod;

    // ------------------------------
    // operand signedness
    // ------------------------------
    always_comb
    begin
        case (i_riscv_mul_op)
            riscv_mext_pkg::MUL, riscv_mext_pkg::MULH:
            begin
                rs1_signed = 1'b1;
                rs2_signed = 1'b1;
            end
            riscv_mext_pkg::MULHSU:
            begin
                rs1_signed = 1'b1;
                rs2_signed = 1'b0;
            end
            default:
            begin
                rs1_signed = 1'b0;
                rs2_signed = 1'b0;
            end
        endcase
    end

    assign rs1_neg = rs1_signed & i_riscv_mul_rs1data[XLEN-1];
    assign rs2_neg = rs2_signed & i_riscv_mul_rs2data[XLEN-1];
    assign rs1_mag = rs1_neg ? (~i_riscv_mul_rs1data + 1'b1) : i_riscv_mul_rs1data;
    assign rs2_mag = rs2_neg ? (~i_riscv_mul_rs2data + 1'b1) : i_riscv_mul_rs2data;

    // ------------------------------
    // shift and add
    // ------------------------------
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < XLEN; i++)
        begin
            if (rs2_mag[i])
                sum = sum + ({{XLEN{1'b0}}, rs1_mag} << i);    // partial product
        end
        prod = (rs1_neg ^ rs2_neg) ? (~sum + 1'b1) : sum;       // restore sign
    end

    always_comb
    begin
        case (i_riscv_mul_op)
            riscv_mext_pkg::MUL:    o_riscv_mul_product = prod[XLEN-1:0];
            riscv_mext_pkg::MULH,
            riscv_mext_pkg::MULHSU,
            riscv_mext_pkg::MULHU:  o_riscv_mul_product = prod[2*XLEN-1:XLEN];
            default:                o_riscv_mul_product = '0;   // divide codes
        endcase
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_riscv_mext -f flist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/tb_riscv_mext_ref.svh ====
`ifndef TB_RISCV_MEXT_REF_SVH
`define TB_RISCV_MEXT_REF_SVH
`default_nettype none

localparam int REF_W = riscv_mext_pkg::XLEN_DEFAULT;

// ------------------------------
// expected result of one M operation
// ------------------------------
function automatic logic [REF_W-1:0] ref_mext(
    input riscv_mext_pkg::mext_op_e op,
    input logic [REF_W-1:0]         a,
    input logic [REF_W-1:0]         b
);
    logic [2*REF_W-1:0] sa;
    logic [2*REF_W-1:0] sb;
    logic [2*REF_W-1:0] ua;
    logic [2*REF_W-1:0] ub;
    logic [2*REF_W-1:0] p_ss;
    logic [2*REF_W-1:0] p_su;
    logic [2*REF_W-1:0] p_uu;
    logic               zero;
    logic               ovf;

    sa   = $signed(a);                      // sign extended to double width
    sb   = $signed(b);
    ua   = a;
    ub   = b;
    p_ss = sa * sb;                         // modulo 2**(2*REF_W) is exact here
    p_su = sa * ub;
    p_uu = ua * ub;
    zero = (b == '0);
    ovf  = (a == {1'b1, {(REF_W-1){1'b0}}}) && (b == '1);
    case (op)
        riscv_mext_pkg::MUL:    return p_ss[REF_W-1:0];
        riscv_mext_pkg::MULH:   return p_ss[2*REF_W-1:REF_W];
        riscv_mext_pkg::MULHSU: return p_su[2*REF_W-1:REF_W];
        riscv_mext_pkg::MULHU:  return p_uu[2*REF_W-1:REF_W];
        riscv_mext_pkg::DIV:    return zero ? '1 : (ovf ? a : REF_W'($signed(sa) / $signed(sb)));
        riscv_mext_pkg::DIVU:   return zero ? '1 : REF_W'(ua / ub);
        riscv_mext_pkg::REM:    return zero ? a : (ovf ? '0 : REF_W'($signed(sa) % $signed(sb)));
        default:                return zero ? a : REF_W'(ua % ub);   // REMU
    endcase
endfunction

// galois form of x^32 + x^22 + x^2 + x + 1, shifts right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

`default_nettype wire
`endif

// ==== tests/tb_riscv_mext.sv ====
`timescale 1ns/1ps
`include "tb_riscv_mext_ref.svh"
`default_nettype none

module tb_riscv_mext;

    localparam int     XLEN        = 64;
    localparam int     CLK_PERIOD  = 8;
    localparam int     BUS_LIMIT   = 100;   // cycles without ack before giving up
    localparam int     NUM_OPS     = 25*4 + 200*4 + 100*4 + 6*4 + 3;
    localparam longint WATCHDOG_NS = longint'(NUM_OPS) * (XLEN + 10) * CLK_PERIOD
                                     + 1000 * CLK_PERIOD;

    logic            clk;
    logic            rst_n;
    logic            wb_cyc;
    logic            wb_stb;
    logic            wb_we;
    logic [2:0]      wb_adr;
    logic [XLEN-1:0] wb_wdat;
    logic [XLEN-1:0] dut_dat;
    logic            dut_ack;
    int              errors;
    int              checks;
    int              ack_wait;              // negedges spent waiting in the last access
    logic [31:0]     lfsr;
    logic [XLEN-1:0] corners [5];

    riscv_mext_top #(.XLEN(XLEN)) dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_wdat),
        .o_wb_dat (dut_dat),
        .o_wb_ack (dut_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    // ------------------------------
    // wishbone master
    // ------------------------------
    // called 1 ns after a rising edge, returns 1 ns after the edge that sees ack
    task automatic bus_access(input logic we, input logic [2:0] adr,
                              input logic [XLEN-1:0] wdat, output logic [XLEN-1:0] rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdat  = wdat;
        ack_wait = 0;
        do
        begin
            @(negedge clk);                 // ack and data are settled here
            ack_wait++;
        end
        while (!dut_ack && ack_wait < BUS_LIMIT);
        if (!dut_ack)
        begin
            $display("ERROR: no ack within %0d cycles for address %0d", BUS_LIMIT, adr);
            errors++;
        end
        rdat = dut_dat;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [XLEN-1:0] dat);
        logic [XLEN-1:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [XLEN-1:0] dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp)
        begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic rand_word(output logic [XLEN-1:0] w);
        for (int i = 0; i < XLEN; i++)
        begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];                 // one step per bit
        end
    endtask

    // full host sequence for one operation
    task automatic run_op(input riscv_mext_pkg::mext_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
        logic [XLEN-1:0] got;
        wb_write(riscv_mext_pkg::REG_RS1, a);
        wb_write(riscv_mext_pkg::REG_RS2, b);
        wb_write(riscv_mext_pkg::REG_OP, XLEN'(op));
        wb_read(riscv_mext_pkg::REG_RESULT, got);
        check_result($sformatf("%s rs1=%h rs2=%h", op.name(), a, b), ref_mext(op, a, b), got);
    endtask

    initial
    begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] got;

        errors     = 0;
        checks     = 0;
        lfsr       = 32'd94;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdat    = '0;
        corners[0] = '0;
        corners[1] = XLEN'(1);
        corners[2] = '1;
        corners[3] = {1'b1, {(XLEN-1){1'b0}}};     // most negative
        corners[4] = {1'b0, {(XLEN-1){1'b1}}};     // most positive
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // ------------------------------
        // multiply
        // ------------------------------
        for (int i = 0; i < 5; i++)
            for (int j = 0; j < 5; j++)
                for (int k = 0; k < 4; k++)
                    run_op(riscv_mext_pkg::mext_op_e'(k), corners[i], corners[j]);
        for (int n = 0; n < 200; n++)
        begin
            rand_word(a);
            rand_word(b);
            for (int k = 0; k < 4; k++)
                run_op(riscv_mext_pkg::mext_op_e'(k), a, b);
        end

        // ------------------------------
        // divide, then special cases
        // ------------------------------
        for (int n = 0; n < 100; n++)
        begin
            rand_word(a);
            rand_word(b);
            b = b >> (n % XLEN);            // spread the quotient sizes
            if (b == '0)
                b = XLEN'(1);
            for (int k = 0; k < 4; k++)
                run_op(riscv_mext_pkg::mext_op_e'(k + 4), a, b);
        end
        for (int i = 0; i < 5; i++)
            for (int k = 0; k < 4; k++)
                run_op(riscv_mext_pkg::mext_op_e'(k + 4), corners[i], '0);
        for (int k = 0; k < 4; k++)
            run_op(riscv_mext_pkg::mext_op_e'(k + 4), corners[3], '1);

        // status around a divide
        rand_word(a);
        rand_word(b);
        wb_write(riscv_mext_pkg::REG_RS1, a);
        wb_write(riscv_mext_pkg::REG_RS2, b);
        wb_write(riscv_mext_pkg::REG_OP, XLEN'(riscv_mext_pkg::DIV));
        wb_read(riscv_mext_pkg::REG_STATUS, got);
        check_status("status during divide", 1'b1, got[0]);
        wb_read(riscv_mext_pkg::REG_RESULT, got);
        check_result("result read while busy", ref_mext(riscv_mext_pkg::DIV, a, b), got);
        wb_read(riscv_mext_pkg::REG_STATUS, got);
        check_status("status after result", 1'b0, got[0]);

        // second start while busy is held off
        wb_write(riscv_mext_pkg::REG_OP, XLEN'(riscv_mext_pkg::DIVU));
        wb_write(riscv_mext_pkg::REG_OP, XLEN'(riscv_mext_pkg::REMU));
        if (ack_wait < XLEN)
        begin
            $display("ERROR: second operation was accepted while the divider was busy");
            errors++;
        end
        wb_read(riscv_mext_pkg::REG_RESULT, got);
        check_result("second op after stall", ref_mext(riscv_mext_pkg::REMU, a, b), got);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
